// ==== include/exec_cfg.svh ====
// execute cluster sizing macros
// data width, rob tag width, station depth

`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// operand and result width
`define DATA_W 32

`define ROB_W 4 // rob tag bits

`define RS_DEPTH 4 // station slots

`endif

// ==== source/exec_pkg.sv ====
// shared types for the execute cluster
// opcode, branch type and station slot state enums

package exec_pkg;

	// adder opcode
	typedef enum logic [0:0] {
		op_add = 1'b0,
		op_sub = 1'b1
	} alu_op_t;

	// any branch forces a subtract
	typedef enum logic [1:0] {
		br_none = 2'b00,
		br_ne   = 2'b01,
		br_eq   = 2'b10,
		br_lt   = 2'b11
	} branch_t;

	typedef enum logic [1:0] {
		rs_free    = 2'b00, // slot empty
		rs_waiting = 2'b01, // an operand still pending
		rs_ready   = 2'b10  // both operands held
	} rs_state_t;

endpackage

// ==== source/ripple_adder.sv ====
// ripple-carry adder/subtractor
// zero, negative, overflow and carry flags

`include "exec_cfg.svh"

module ripple_adder (
	input  logic [`DATA_W-1:0] a,
	input  logic [`DATA_W-1:0] b,
	input  logic               subtract,
	output logic [`DATA_W-1:0] sum,
	output logic               zero,
	output logic               negative,
	output logic               overflow,
	output logic               carry
);
	logic [`DATA_W:0]   c;
	logic [`DATA_W-1:0] b_eff;

	// two's complement, invert b and carry in one
	assign b_eff = subtract ? ~b : b;
	assign c[0] = subtract;

	for (genvar i = 0; i < `DATA_W; i++) begin : g_bit
		logic p; // propagate

		assign p = a[i] ^ b_eff[i];
		assign sum[i] = p ^ c[i];
		assign c[i+1] = (a[i] & b_eff[i]) | (p & c[i]);
	end

	assign carry = c[`DATA_W];
	assign overflow = c[`DATA_W] ^ c[`DATA_W-1]; // carry into vs out of sign bit
	assign zero = (sum == '0);
	assign negative = sum[`DATA_W-1];

endmodule

// ==== source/reservation_station.sv ====
// reservation station for the add/sub unit
// holds dispatched entries, wakes operands off the cdb, issues oldest ready

`include "exec_cfg.svh"

module reservation_station
	import exec_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 dispatch_valid,
	input  logic [`ROB_W-1:0]    dispatch_rob,
	input  alu_op_t              dispatch_op,
	input  branch_t              dispatch_branch,
	input  logic                 dispatch_load,
	input  logic [`DATA_W-1:0]   src1_value,
	input  logic [`ROB_W-1:0]    src1_tag,
	input  logic                 src1_ready,
	input  logic [`DATA_W-1:0]   src2_value,
	input  logic [`ROB_W-1:0]    src2_tag,
	input  logic                 src2_ready,
	input  logic                 unit_ready,
	input  logic                 wake_valid,
	input  logic [`ROB_W-1:0]    wake_rob,
	input  logic [`DATA_W-1:0]   wake_result,
	output logic                 rs_full,
	output logic                 issue_valid,
	output logic [`DATA_W-1:0]   issue_rs1,
	output logic [`DATA_W-1:0]   issue_rs2,
	output logic [`ROB_W-1:0]    issue_rob,
	output alu_op_t              issue_op,
	output branch_t              issue_branch,
	output logic                 issue_load
);
	localparam int IDX_W = $clog2(`RS_DEPTH);
	localparam int AGE_W = IDX_W + 1;

	rs_state_t            state [`RS_DEPTH];
	logic [AGE_W-1:0]     age [`RS_DEPTH]; // bigger is older
	logic                 rdy1 [`RS_DEPTH];
	logic                 rdy2 [`RS_DEPTH];
	logic                 hit1 [`RS_DEPTH];
	logic                 hit2 [`RS_DEPTH];
	logic [`DATA_W-1:0]   val1 [`RS_DEPTH];
	logic [`DATA_W-1:0]   val2 [`RS_DEPTH];
	logic [`ROB_W-1:0]    tag1 [`RS_DEPTH];
	logic [`ROB_W-1:0]    tag2 [`RS_DEPTH];
	logic [`ROB_W-1:0]    rob_q [`RS_DEPTH];
	alu_op_t              op_q [`RS_DEPTH];
	branch_t              br_q [`RS_DEPTH];
	logic                 load_q [`RS_DEPTH];

	logic                 free_found;
	logic [IDX_W-1:0]     free_idx;
	logic                 issue_found;
	logic [IDX_W-1:0]     issue_idx;
	logic [AGE_W-1:0]     best_age;
	logic                 dispatch_ok;
	logic                 d_rdy1;
	logic                 d_rdy2;
	logic [`DATA_W-1:0]   d_val1;
	logic [`DATA_W-1:0]   d_val2;

	// lowest free slot
	always_comb begin
		free_found = 1'b0;
		free_idx = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (state[i] == rs_free) begin
				free_found = 1'b1;
				free_idx = IDX_W'(i);
			end
		end
	end

	// oldest ready slot
	always_comb begin
		issue_found = 1'b0;
		issue_idx = '0;
		best_age = '0;
		for (int i = 0; i < `RS_DEPTH; i++) begin
			if (state[i] == rs_ready && (!issue_found || age[i] > best_age)) begin
				issue_found = 1'b1;
				issue_idx = IDX_W'(i);
				best_age = age[i];
			end
		end
	end

	// tag match against the broadcast, per slot
	always_comb begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			hit1[i] = state[i] == rs_waiting && !rdy1[i] && wake_valid && wake_rob == tag1[i];
			hit2[i] = state[i] == rs_waiting && !rdy2[i] && wake_valid && wake_rob == tag2[i];
		end
	end

	// a producer may broadcast in the dispatch cycle itself
	always_comb begin
		d_rdy1 = src1_ready;
		d_val1 = src1_value;
		d_rdy2 = src2_ready;
		d_val2 = src2_value;
		if (!src1_ready && wake_valid && wake_rob == src1_tag) begin
			d_rdy1 = 1'b1;
			d_val1 = wake_result;
		end
		if (!src2_ready && wake_valid && wake_rob == src2_tag) begin
			d_rdy2 = 1'b1;
			d_val2 = wake_result;
		end
	end

	assign rs_full = !free_found;
	assign dispatch_ok = dispatch_valid && free_found; // lost when full
	assign issue_valid = issue_found && unit_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RS_DEPTH; i++) begin
				state[i] <= rs_free;
				age[i] <= '0;
				rdy1[i] <= 1'b0;
				rdy2[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < `RS_DEPTH; i++) begin
				if (state[i] == rs_waiting && (rdy1[i] || hit1[i]) && (rdy2[i] || hit2[i]))
					state[i] <= rs_ready;
				if (hit1[i])
					rdy1[i] <= 1'b1;
				if (hit2[i])
					rdy2[i] <= 1'b1;
				// age counts the younger slots still held
				if (state[i] != rs_free)
					age[i] <= age[i] + AGE_W'(dispatch_ok)
						- AGE_W'(issue_valid && age[i] > age[issue_idx]);
			end
			if (issue_valid)
				state[issue_idx] <= rs_free;
			if (dispatch_ok) begin
				state[free_idx] <= (d_rdy1 && d_rdy2) ? rs_ready : rs_waiting;
				age[free_idx] <= '0;
				rdy1[free_idx] <= d_rdy1;
				rdy2[free_idx] <= d_rdy2;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `RS_DEPTH; i++) begin
			if (hit1[i])
				val1[i] <= wake_result;
			if (hit2[i])
				val2[i] <= wake_result;
		end
		if (dispatch_ok) begin
			val1[free_idx] <= d_val1;
			val2[free_idx] <= d_val2;
			tag1[free_idx] <= src1_tag;
			tag2[free_idx] <= src2_tag;
			rob_q[free_idx] <= dispatch_rob;
			op_q[free_idx] <= dispatch_op;
			br_q[free_idx] <= dispatch_branch;
			load_q[free_idx] <= dispatch_load;
		end
	end

	assign issue_rs1 = val1[issue_idx];
	assign issue_rs2 = val2[issue_idx];
	assign issue_rob = rob_q[issue_idx];
	assign issue_op = op_q[issue_idx];
	assign issue_branch = br_q[issue_idx];
	assign issue_load = load_q[issue_idx];

	a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
		dispatch_valid |-> !rs_full)
		else $error("dispatch while station full");

	// unit must have been free, and must go busy after taking it
	a_issue_handshake: assert property (@(posedge clk) disable iff (rst)
		issue_valid |-> unit_ready ##1 !unit_ready)
		else $error("issue without unit ready");

endmodule

// ==== source/add_sub_unit.sv ====
// integer add/sub functional unit
// registers the adder result and branch outcome, holds them until yumi

`include "exec_cfg.svh"

module add_sub_unit
	import exec_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               valid_in,
	input  logic               yumi,
	input  alu_op_t            op,
	input  branch_t            branch,
	input  logic               load,
	input  logic [`ROB_W-1:0]  rob_entry,
	input  logic [`DATA_W-1:0] rs1,
	input  logic [`DATA_W-1:0] rs2,
	output logic               ready,
	output logic               valid_out,
	output logic [`DATA_W-1:0] result,
	output logic               branch_taken,
	output logic [`ROB_W-1:0]  dest_rob,
	output logic               load_flag
);
	logic               subtract;
	logic [`DATA_W-1:0] sum;
	logic               zero;
	logic               negative;
	logic               overflow;
	logic               taken_next;

	// branches compare via rs1 - rs2
	assign subtract = (op == op_sub) || (branch != br_none);

	ripple_adder adder_inst (
		.a        (rs1),
		.b        (rs2),
		.subtract (subtract),
		.sum      (sum),
		.zero     (zero),
		.negative (negative),
		.overflow (overflow),
		.carry    ()
	);

	always_comb begin
		case (branch)
			br_ne:   taken_next = !zero;
			br_eq:   taken_next = zero;
			br_lt:   taken_next = negative ^ overflow; // signed less than
			default: taken_next = 1'b0;
		endcase
	end

	// one result in flight, busy until the driver takes it
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_out <= 1'b0;
			ready <= 1'b1;
		end else if (valid_in) begin
			valid_out <= 1'b1;
			ready <= 1'b0;
		end else if (yumi) begin
			valid_out <= 1'b0;
			ready <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_in) begin
			result <= sum;
			branch_taken <= taken_next;
			dest_rob <= rob_entry;
			load_flag <= load;
		end
	end

	a_no_issue_when_busy: assert property (@(posedge clk) disable iff (rst)
		valid_in |-> !valid_out ##1 valid_out)
		else $error("issue into busy unit");

	a_operands_known: assert property (@(posedge clk) disable iff (rst)
		valid_in |-> !$isunknown({rs1, rs2}))
		else $error("adder operands X at issue");

endmodule

// ==== source/cdb_driver.sv ====
// cdb driver, one-entry result buffer
// takes the unit's packet and drives the bus until granted

`include "exec_cfg.svh"

module cdb_driver (
	input  logic               clk,
	input  logic               rst,
	input  logic               unit_valid,
	input  logic [`DATA_W-1:0] unit_result,
	input  logic               unit_branch_taken,
	input  logic [`ROB_W-1:0]  unit_rob,
	input  logic               unit_load,
	input  logic               cdb_grant,
	output logic               yumi,
	output logic               cdb_valid,
	output logic [`ROB_W-1:0]  cdb_rob,
	output logic [`DATA_W-1:0] cdb_result,
	output logic               cdb_branch_taken,
	output logic               cdb_load
);
	// take a packet only into an empty buffer
	assign yumi = unit_valid && !cdb_valid;

	always_ff @(posedge clk) begin
		if (rst)
			cdb_valid <= 1'b0;
		else if (yumi)
			cdb_valid <= 1'b1;
		else if (cdb_valid && cdb_grant)
			cdb_valid <= 1'b0; // broadcast done
	end

	always_ff @(posedge clk) begin
		if (yumi) begin
			cdb_rob <= unit_rob;
			cdb_result <= unit_result;
			cdb_branch_taken <= unit_branch_taken;
			cdb_load <= unit_load;
		end
	end

	a_hold_until_grant: assert property (@(posedge clk) disable iff (rst)
		cdb_valid && !cdb_grant |=> cdb_valid
			&& $stable({cdb_rob, cdb_result, cdb_branch_taken, cdb_load}))
		else $error("cdb packet changed before grant");

endmodule

// ==== source/exec_cluster.sv ====
// execute cluster top
// station, add/sub unit and cdb driver, with cdb loopback for wakeup

`include "exec_cfg.svh"

module exec_cluster
	import exec_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic               dispatch_valid,
	input  logic [`ROB_W-1:0]  dispatch_rob,
	input  alu_op_t            dispatch_op,
	input  branch_t            dispatch_branch,
	input  logic               dispatch_load,
	input  logic [`DATA_W-1:0] src1_value,
	input  logic [`ROB_W-1:0]  src1_tag,
	input  logic               src1_ready,
	input  logic [`DATA_W-1:0] src2_value,
	input  logic [`ROB_W-1:0]  src2_tag,
	input  logic               src2_ready,
	input  logic               cdb_grant,
	output logic               rs_full,
	output logic               cdb_valid,
	output logic [`ROB_W-1:0]  cdb_rob,
	output logic [`DATA_W-1:0] cdb_result,
	output logic               cdb_branch_taken,
	output logic               cdb_load
);
	logic               issue_valid;
	logic [`DATA_W-1:0] issue_rs1;
	logic [`DATA_W-1:0] issue_rs2;
	logic [`ROB_W-1:0]  issue_rob;
	alu_op_t            issue_op;
	branch_t            issue_branch;
	logic               issue_load;
	logic               unit_ready;
	logic               unit_valid;
	logic [`DATA_W-1:0] unit_result;
	logic               unit_branch_taken;
	logic [`ROB_W-1:0]  unit_rob;
	logic               unit_load;
	logic               yumi;
	logic               wake_valid;

	assign wake_valid = cdb_valid & cdb_grant; // only a granted broadcast wakes

	reservation_station station_inst (
		.clk, .rst, .dispatch_valid, .dispatch_rob, .dispatch_op, .dispatch_branch,
		.dispatch_load, .src1_value, .src1_tag, .src1_ready, .src2_value, .src2_tag,
		.src2_ready, .unit_ready, .wake_valid,
		.wake_rob (cdb_rob),
		.wake_result (cdb_result),
		.rs_full, .issue_valid, .issue_rs1, .issue_rs2, .issue_rob, .issue_op,
		.issue_branch, .issue_load
	);

	add_sub_unit unit_inst (
		.clk, .rst,
		.valid_in (issue_valid),
		.yumi, .op (issue_op), .branch (issue_branch), .load (issue_load),
		.rob_entry (issue_rob), .rs1 (issue_rs1), .rs2 (issue_rs2),
		.ready (unit_ready), .valid_out (unit_valid), .result (unit_result),
		.branch_taken (unit_branch_taken), .dest_rob (unit_rob), .load_flag (unit_load)
	);

	cdb_driver driver_inst (
		.clk, .rst, .unit_valid, .unit_result, .unit_branch_taken, .unit_rob,
		.unit_load, .cdb_grant, .yumi, .cdb_valid, .cdb_rob, .cdb_result,
		.cdb_branch_taken, .cdb_load
	);

endmodule

// ==== test/tb_clock.sv ====
// testbench clock source
// free running, starts low

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk; // half period per phase
	end

endmodule

// ==== test/exec_cluster_tb.sv ====
// testbench for the execute cluster
// replays dispatch vectors under random cdb grant, checks every broadcast

`include "exec_cfg.svh"

module exec_cluster_tb
	import exec_pkg::*;
();
	localparam int NREC = 16;
	localparam int NCOL = 12;
	localparam int NROB = 1 << `ROB_W;
	localparam int MAX_CYCLES = 4000;
	localparam int FILL_LIMIT = 200;

	logic                 clk;
	logic                 rst;
	logic                 dispatch_valid;
	logic [`ROB_W-1:0]    dispatch_rob;
	alu_op_t              dispatch_op;
	branch_t              dispatch_branch;
	logic                 dispatch_load;
	logic [`DATA_W-1:0]   src1_value;
	logic [`ROB_W-1:0]    src1_tag;
	logic                 src1_ready;
	logic [`DATA_W-1:0]   src2_value;
	logic [`ROB_W-1:0]    src2_tag;
	logic                 src2_ready;
	logic                 cdb_grant;
	logic                 rs_full;
	logic                 cdb_valid;
	logic [`ROB_W-1:0]    cdb_rob;
	logic [`DATA_W-1:0]   cdb_result;
	logic                 cdb_branch_taken;
	logic                 cdb_load;

	logic [31:0]          vec_mem [NREC*NCOL]; // NCOL words per record
	logic [`DATA_W-1:0]   exp_result [NROB];
	logic                 exp_taken [NROB];
	logic                 exp_load [NROB];
	bit                   in_file [NROB];
	bit                   dispatched [NROB];
	bit                   seen [NROB];

	// packet left on the bus without grant
	bit                   held;
	logic [`ROB_W-1:0]    held_rob;
	logic [`DATA_W-1:0]   held_result;
	logic                 held_taken;
	logic                 held_load;

	tb_clock #(.PERIOD(40)) clock_inst (.clk);

	exec_cluster exec_cluster_inst (.*);

	task automatic report_failure();
		$display("test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic load_expected();
		logic [`ROB_W-1:0] rob;
		for (int r = 0; r < NREC; r++) begin
			rob = vec_mem[r*NCOL][`ROB_W-1:0];
			assert (!in_file[rob]) else begin
				$display("vector file repeats rob entry %0d or did not load", rob);
				report_failure();
			end
			in_file[rob] = 1'b1;
			exp_result[rob] = vec_mem[r*NCOL + 10];
			exp_taken[rob] = vec_mem[r*NCOL + 11][0];
			exp_load[rob] = vec_mem[r*NCOL + 3][0];
		end
	endtask

	// a pending source whose producer already broadcast goes out as a value
	task automatic drive_dispatch(input int r);
		int base;
		logic [`ROB_W-1:0] t1;
		logic [`ROB_W-1:0] t2;
		base = r * NCOL;
		t1 = vec_mem[base + 5][`ROB_W-1:0];
		t2 = vec_mem[base + 8][`ROB_W-1:0];
		dispatched[vec_mem[base][`ROB_W-1:0]] = 1'b1;
		dispatch_valid <= 1'b1;
		dispatch_rob <= vec_mem[base][`ROB_W-1:0];
		dispatch_op <= alu_op_t'(vec_mem[base + 1][0]);
		dispatch_branch <= branch_t'(vec_mem[base + 2][1:0]);
		dispatch_load <= vec_mem[base + 3][0];
		src1_tag <= t1;
		src2_tag <= t2;
		src1_ready <= vec_mem[base + 4][0] || seen[t1];
		src2_ready <= vec_mem[base + 7][0] || seen[t2];
		if (vec_mem[base + 4][0])
			src1_value <= vec_mem[base + 6];
		else
			src1_value <= seen[t1] ? exp_result[t1] : '0;
		if (vec_mem[base + 7][0])
			src2_value <= vec_mem[base + 9];
		else
			src2_value <= seen[t2] ? exp_result[t2] : '0;
	endtask

	task automatic check_broadcast();
		logic [`ROB_W-1:0] rob;
		rob = cdb_rob;
		assert (dispatched[rob]) else begin
			$display("ERROR cdb_rob = %h was never dispatched", rob);
			report_failure();
		end
		assert (!seen[rob]) else begin
			$display("ERROR cdb_rob = %h broadcast a second time", rob);
			report_failure();
		end
		assert (cdb_result === exp_result[rob]) else begin
			$display("ERROR cdb_result = %h expected %h (rob %h)", cdb_result, exp_result[rob], rob);
			report_failure();
		end
		assert (cdb_branch_taken === exp_taken[rob]) else begin
			$display("ERROR cdb_branch_taken = %h expected %h (rob %h)",
				cdb_branch_taken, exp_taken[rob], rob);
			report_failure();
		end
		assert (cdb_load === exp_load[rob]) else begin
			$display("ERROR cdb_load = %h expected %h (rob %h)", cdb_load, exp_load[rob], rob);
			report_failure();
		end
		seen[rob] = 1'b1;
	endtask

	task automatic check_held_packet();
		assert (cdb_valid === 1'b1) else begin
			$display("ERROR cdb_valid = %h dropped before grant, expected 1", cdb_valid);
			report_failure();
		end
		assert (cdb_rob === held_rob) else begin
			$display("ERROR cdb_rob = %h changed before grant, expected %h", cdb_rob, held_rob);
			report_failure();
		end
		assert ({cdb_result, cdb_branch_taken, cdb_load} === {held_result, held_taken, held_load})
		else begin
			$display("ERROR cdb_result/cdb_branch_taken/cdb_load = %h %h %h expected %h %h %h",
				cdb_result, cdb_branch_taken, cdb_load, held_result, held_taken, held_load);
			report_failure();
		end
	endtask

	initial begin
		int next_rec;
		int cycles;
		int gap;
		int seen_count;
		int grant_left;
		int low_run;
		bit saw_full;
		bit grant_level;
		bit grant_next;
		bit send;

		void'($urandom(32'h11d8));
		$readmemh("test/exec_vectors.txt", vec_mem);
		load_expected();
		rst = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_rob = '0;
		dispatch_op = op_add;
		dispatch_branch = br_none;
		dispatch_load = 1'b0;
		src1_value = '0;
		src1_tag = '0;
		src1_ready = 1'b0;
		src2_value = '0;
		src2_tag = '0;
		src2_ready = 1'b0;
		cdb_grant = 1'b0;

		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (cdb_valid === 1'b0) else begin
			$display("ERROR cdb_valid = %h after reset, expected 0", cdb_valid);
			report_failure();
		end
		assert (rs_full === 1'b0) else begin
			$display("ERROR rs_full = %h after reset, expected 0", rs_full);
			report_failure();
		end

		while (seen_count < NREC) begin
			@(negedge clk); // outputs settled, grant as sampled at the next edge
			cycles++;
			if (cycles > MAX_CYCLES) begin
				$display("timed out with %0d of %0d rob entries broadcast", seen_count, NREC);
				report_failure();
			end
			if (held)
				check_held_packet();
			if (cdb_valid && cdb_grant) begin
				check_broadcast();
				seen_count++;
			end
			held = cdb_valid && !cdb_grant;
			held_rob = cdb_rob;
			held_result = cdb_result;
			held_taken = cdb_branch_taken;
			held_load = cdb_load;
			saw_full = saw_full || rs_full;

			// grant held off until the station backs up, random stretches after
			if (!saw_full) begin
				grant_next = 1'b0;
				low_run++;
				if (low_run > FILL_LIMIT) begin
					$display("station never filled while the cdb grant was held low");
					report_failure();
				end
			end else begin
				if (grant_left == 0) begin
					grant_level = ($urandom_range(1, 0) == 1);
					grant_left = $urandom_range(24, 1);
				end
				grant_left--;
				grant_next = grant_level;
			end

			// one idle cycle between dispatches keeps rs_full current
			send = 1'b0;
			if (gap > 0)
				gap--;
			else if (!dispatch_valid && !rs_full && next_rec < NREC)
				send = 1'b1;

			@(posedge clk);
			cdb_grant <= grant_next;
			if (send) begin
				drive_dispatch(next_rec);
				next_rec++;
				gap = $urandom_range(3, 0);
			end else begin
				dispatch_valid <= 1'b0;
			end
		end

		@(negedge clk);
		assert (cdb_valid === 1'b0) else begin
			$display("ERROR cdb_valid = %h after the last broadcast, expected 0", cdb_valid);
			report_failure();
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== test/exec_vectors.txt ====
// one dispatch per line, hex: rob op branch load src1_ready src1_tag src1_value
// src2_ready src2_tag src2_value result taken
// op 0 add 1 sub; branch 0 none 1 ne 2 eq 3 lt; a pending source tags its producer rob
// add and sub, wraparound, negative difference
0 0 0 0 1 0 00000005 1 0 00000007 0000000c 0
1 0 0 0 1 0 ffffffff 1 0 00000002 00000001 0
2 1 0 0 1 0 00000003 1 0 00000005 fffffffe 0
// load address generation
3 0 0 1 1 0 00001000 1 0 00000020 00001020 0
// beq and bne, branch forces a subtract even with op add
4 0 2 0 1 0 0000002a 1 0 0000002a 00000000 1
5 1 1 0 1 0 0000002a 1 0 0000002b ffffffff 1
6 0 1 0 1 0 12345678 1 0 12345678 00000000 0
// blt, signed overflow in 7 and 8
7 1 3 0 1 0 80000000 1 0 00000001 7fffffff 1
8 0 3 0 1 0 7fffffff 1 0 ffffffff 80000000 0
9 1 3 0 1 0 00000003 1 0 00000009 fffffffa 1
// dependent chain, operands woken from the cdb
a 0 0 0 0 0 00000000 1 0 00000100 0000010c 0
b 1 0 0 0 a 00000000 0 1 00000000 0000010b 0
c 0 2 0 0 b 00000000 1 0 0000010b 00000000 1
d 0 0 1 0 3 00000000 1 0 00000004 00001024 0
e 1 3 0 1 0 00000005 0 2 00000000 00000007 0
f 1 0 0 0 d 00000000 0 e 00000000 0000101d 0

// ==== src.f ====
+incdir+include
source/exec_pkg.sv
source/ripple_adder.sv
source/reservation_station.sv
source/add_sub_unit.sv
source/cdb_driver.sv
source/exec_cluster.sv
test/tb_clock.sv
test/exec_cluster_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute cluster testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module exec_cluster_tb \
	-Mdir obj_dir \
	-f src.f

output=$(./obj_dir/Vexec_cluster_tb 2>&1) || true
echo "$output"

if grep -qx "test passed" <<< "$output"; then
	exit 0
fi
exit 1
